/* hw/regif_pkg.sv */
// shared data types and register numbers of the host register interface

package regif_pkg;

    typedef logic [7:0]  byte_t;    // one bus byte
    typedef logic [15:0] word_t;    // register or memory word
    typedef logic [15:0] addr_t;    // VRAM or XR address
    typedef logic [3:0]  reg_num_t; // bus register number
    typedef logic [6:0]  intr_t;    // one bit per interrupt source
    typedef logic [3:0]  wrmask_t;  // VRAM nibble write mask

    // system and interrupt control
    localparam reg_num_t REG_SYS_CTRL = 4'h0;
    localparam reg_num_t REG_INT_CTRL = 4'h1;
    localparam reg_num_t REG_TIMER    = 4'h2;

    // XR channel
    localparam reg_num_t REG_RD_XADDR = 4'h3;
    localparam reg_num_t REG_WR_XADDR = 4'h4;
    localparam reg_num_t REG_XDATA    = 4'h5;

    // VRAM channel
    localparam reg_num_t REG_RD_INCR  = 4'h6;
    localparam reg_num_t REG_RD_ADDR  = 4'h7;
    localparam reg_num_t REG_WR_INCR  = 4'h8;
    localparam reg_num_t REG_WR_ADDR  = 4'h9;
    localparam reg_num_t REG_DATA     = 4'hA;

    // 0xB to 0xF are unused, they read as zero

endpackage

/* hw/bus_sync.sv */
// CPU bus synchronizer producing read and write byte strobes with captured bus fields
`timescale 1ns/1ps

module bus_sync
    import regif_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     bus_cs_n_i,    // async chip select, active low
    input  logic     bus_rd_nwr_i,  // 1 = read, 0 = write
    input  reg_num_t bus_reg_num_i,
    input  logic     bus_bytesel_i, // 0 = even (high) byte
    input  byte_t    bus_data_i,
    output logic     wr_strobe_o,
    output logic     rd_strobe_o,
    output reg_num_t reg_num_o,
    output logic     bytesel_o,
    output byte_t    wr_byte_o
);

    logic cs_meta;   // first synchronizer stage
    logic cs_sync;   // second synchronizer stage
    logic cs_last;   // previous synchronized value
    logic cs_fall;

    assign cs_fall = cs_last & ~cs_sync;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_meta     <= 1'b1;
            cs_sync     <= 1'b1;
            cs_last     <= 1'b1;
            wr_strobe_o <= 1'b0;
            rd_strobe_o <= 1'b0;
            reg_num_o   <= '0;
            bytesel_o   <= 1'b0;
            wr_byte_o   <= '0;
        end else begin
            cs_meta     <= bus_cs_n_i;
            cs_sync     <= cs_meta;
            cs_last     <= cs_sync;
            wr_strobe_o <= cs_fall & ~bus_rd_nwr_i;
            rd_strobe_o <= cs_fall & bus_rd_nwr_i;
            if (cs_fall) begin
                // bus lines have been stable for two cycles by now
                reg_num_o <= bus_reg_num_i;
                bytesel_o <= bus_bytesel_i;
                wr_byte_o <= bus_data_i;
            end
        end
    end

endmodule

/* hw/access_channel.sv */
// memory access channel with read/write address, increment and data registers
`timescale 1ns/1ps

module access_channel
    import regif_pkg::*;
#(
    parameter bit       HAS_INCR    = 1'b1,
    parameter reg_num_t RD_ADDR_NUM = REG_RD_ADDR,
    parameter reg_num_t WR_ADDR_NUM = REG_WR_ADDR,
    parameter reg_num_t DATA_NUM    = REG_DATA,
    parameter reg_num_t RD_INCR_NUM = REG_RD_INCR,
    parameter reg_num_t WR_INCR_NUM = REG_WR_INCR
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     wr_strobe_i,
    input  logic     rd_strobe_i,
    input  reg_num_t reg_num_i,
    input  logic     bytesel_i,
    input  byte_t    wr_byte_i,
    input  logic     ack_i,
    input  word_t    rdata_i,
    output logic     sel_o,
    output logic     wr_o,
    output addr_t    addr_o,
    output word_t    wdata_o,
    output logic     busy_o,
    output logic     rd_hit_o,
    output word_t    rd_word_o
);

    addr_t rd_addr;
    addr_t wr_addr;
    word_t rd_incr;     // stays zero without HAS_INCR
    word_t wr_incr;
    word_t rd_data;     // last word read from memory
    byte_t data_even;   // even byte waiting for the odd write
    logic  rd_pend;     // read outstanding
    logic  rd_adv;      // advance read address next edge
    logic  wr_adv;
    logic  wr_odd;      // odd byte write strobe
    word_t rd_step;
    word_t wr_step;

    assign wr_odd  = wr_strobe_i & bytesel_i;
    assign rd_step = HAS_INCR ? rd_incr : 16'd1;
    assign wr_step = HAS_INCR ? wr_incr : 16'd1;
    assign busy_o  = rd_pend | wr_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_o   <= 1'b0;
            wr_o    <= 1'b0;
            rd_pend <= 1'b0;
            rd_adv  <= 1'b0;
            wr_adv  <= 1'b0;
            rd_addr <= '0;
            wr_addr <= '0;
            rd_incr <= '0;
            wr_incr <= '0;
            rd_data <= '0;
        end else begin
            rd_adv <= ack_i & rd_pend;
            wr_adv <= ack_i & wr_o;
            if (ack_i) begin
                if (rd_pend) begin
                    rd_data <= rdata_i;
                end
                sel_o   <= 1'b0;
                wr_o    <= 1'b0;
                rd_pend <= 1'b0;
            end
            if (rd_adv) begin
                rd_addr <= rd_addr + rd_step;
            end
            if (wr_adv) begin
                wr_addr <= wr_addr + wr_step;
            end
            // bus writes come last so they win over the address advance
            if (wr_strobe_i) begin
                if (reg_num_i == RD_ADDR_NUM) begin
                    if (!bytesel_i) begin
                        rd_addr[15:8] <= wr_byte_i;
                    end else begin
                        rd_addr[7:0] <= wr_byte_i;
                        sel_o        <= 1'b1;   // read the new address
                        rd_pend      <= 1'b1;
                    end
                end else if (reg_num_i == WR_ADDR_NUM) begin
                    if (!bytesel_i) wr_addr[15:8] <= wr_byte_i;
                    else            wr_addr[7:0]  <= wr_byte_i;
                end else if (HAS_INCR && reg_num_i == RD_INCR_NUM) begin
                    if (!bytesel_i) rd_incr[15:8] <= wr_byte_i;
                    else            rd_incr[7:0]  <= wr_byte_i;
                end else if (HAS_INCR && reg_num_i == WR_INCR_NUM) begin
                    if (!bytesel_i) wr_incr[15:8] <= wr_byte_i;
                    else            wr_incr[7:0]  <= wr_byte_i;
                end else if (reg_num_i == DATA_NUM && bytesel_i) begin
                    sel_o <= 1'b1;
                    wr_o  <= 1'b1;
                end
            end
            if (rd_strobe_i && bytesel_i && reg_num_i == DATA_NUM) begin
                sel_o   <= 1'b1;    // pre-read next word
                rd_pend <= 1'b1;
            end
        end
    end

    // address and payload held until the next request
    always_ff @(posedge clk) begin
        if (wr_strobe_i && !bytesel_i && reg_num_i == DATA_NUM) begin
            data_even <= wr_byte_i;
        end
        if (wr_odd && reg_num_i == RD_ADDR_NUM) begin
            addr_o <= {rd_addr[15:8], wr_byte_i};
        end else if (wr_odd && reg_num_i == DATA_NUM) begin
            addr_o  <= wr_addr;
            wdata_o <= {data_even, wr_byte_i};
        end else if (rd_strobe_i && bytesel_i && reg_num_i == DATA_NUM) begin
            addr_o <= rd_addr;
        end
    end

    always_comb begin
        rd_hit_o  = 1'b1;
        rd_word_o = '0;
        if (reg_num_i == RD_ADDR_NUM) begin
            rd_word_o = rd_addr;
        end else if (reg_num_i == WR_ADDR_NUM) begin
            rd_word_o = wr_addr;
        end else if (reg_num_i == DATA_NUM) begin
            rd_word_o = rd_data;
        end else if (HAS_INCR && reg_num_i == RD_INCR_NUM) begin
            rd_word_o = rd_incr;
        end else if (HAS_INCR && reg_num_i == WR_INCR_NUM) begin
            rd_word_o = wr_incr;
        end else begin
            rd_hit_o = 1'b0;    // not one of ours
        end
    end

endmodule

/* hw/tick_timer.sv */
// fractional-divider 1/10 ms counter with latched low byte
`timescale 1ns/1ps

module tick_timer
    import regif_pkg::*;
#(
    parameter integer CLK_REDUCED = 5025,
    parameter integer HZ_REDUCED  = 2
) (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  rd_strobe_i,
    input  logic  bytesel_i,
    output word_t timer_word_o
);

    // one extra bit so the accumulator can go negative after a wrap
    localparam integer FRAC_BITS = $clog2(CLK_REDUCED) + 1;
    localparam logic [FRAC_BITS-1:0] STEP      = FRAC_BITS'(HZ_REDUCED);
    localparam logic [FRAC_BITS-1:0] STEP_WRAP = FRAC_BITS'(HZ_REDUCED - CLK_REDUCED);

    logic [FRAC_BITS-1:0] frac;
    word_t                count;
    byte_t                low_latch;
    logic                 tick;

    assign tick = ~frac[FRAC_BITS-1];   // accumulator non-negative

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac      <= '0;
            count     <= '0;
            low_latch <= '0;
        end else begin
            if (tick) begin
                frac  <= frac + STEP_WRAP;
                count <= count + 16'd1;
            end else begin
                frac <= frac + STEP;
            end
            if (rd_strobe_i && !bytesel_i) begin
                low_latch <= count[7:0];  // keeps the word coherent
            end
        end
    end

    assign timer_word_o = {count[15:8], low_latch};

endmodule

/* hw/sys_regs.sv */
// system and interrupt control registers with the bus read-data multiplexer
`timescale 1ns/1ps

module sys_regs
    import regif_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     wr_strobe_i,
    input  reg_num_t reg_num_i,
    input  logic     bytesel_i,
    input  byte_t    wr_byte_i,
    input  word_t    timer_word_i,
    input  logic     vram_busy_i,
    input  logic     xr_busy_i,
    input  logic     vram_hit_i,
    input  word_t    vram_word_i,
    input  logic     xr_hit_i,
    input  word_t    xr_word_i,
    input  logic     h_blank_i,
    input  logic     v_blank_i,
    input  intr_t    intr_status_i,
    output wrmask_t  wrmask_o,
    output intr_t    intr_mask_o,
    output intr_t    intr_clear_o,
    output byte_t    bus_data_o
);

    word_t rd_word;
    logic  mem_busy;

    assign mem_busy = vram_busy_i | xr_busy_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wrmask_o     <= 4'b1111;    // all nibbles enabled
            intr_mask_o  <= '0;
            intr_clear_o <= '0;
        end else begin
            intr_clear_o <= '0;         // one cycle pulse
            if (wr_strobe_i) begin
                if (reg_num_i == REG_SYS_CTRL && bytesel_i) begin
                    wrmask_o <= wr_byte_i[3:0];
                end
                if (reg_num_i == REG_INT_CTRL) begin
                    if (!bytesel_i) intr_mask_o  <= wr_byte_i[6:0];
                    else            intr_clear_o <= wr_byte_i[6:0];
                end
            end
        end
    end

    always_comb begin
        case (reg_num_i)
            REG_SYS_CTRL: rd_word = {mem_busy, 3'b000, h_blank_i, v_blank_i, 6'b0, wrmask_o};
            REG_INT_CTRL: rd_word = {1'b0, intr_mask_o, 1'b0, intr_status_i};
            REG_TIMER:    rd_word = timer_word_i;
            default: begin
                if (vram_hit_i)    rd_word = vram_word_i;
                else if (xr_hit_i) rd_word = xr_word_i;
                else               rd_word = '0;    // unused numbers
            end
        endcase
    end

    assign bus_data_o = bytesel_i ? rd_word[7:0] : rd_word[15:8];

endmodule

/* hw/reg_interface.sv */
// top level of the host register interface: bus sync, VRAM and XR channels, timer, system regs
`timescale 1ns/1ps

module reg_interface
    import regif_pkg::*;
#(
    parameter integer CLK_REDUCED = 5025,   // 10 kHz from 25.125 MHz
    parameter integer HZ_REDUCED  = 2
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     bus_cs_n_i,
    input  logic     bus_rd_nwr_i,
    input  reg_num_t bus_reg_num_i,
    input  logic     bus_bytesel_i,
    input  byte_t    bus_data_i,
    output byte_t    bus_data_o,
    input  logic     vram_ack_i,
    input  word_t    vram_rdata_i,
    output logic     vram_sel_o,
    output logic     vram_wr_o,
    output addr_t    vram_addr_o,
    output word_t    vram_data_o,
    output wrmask_t  wrmask_o,
    input  logic     xr_ack_i,
    input  word_t    xr_rdata_i,
    output logic     xr_sel_o,
    output logic     xr_wr_o,
    output addr_t    xr_addr_o,
    output word_t    xr_data_o,
    input  logic     h_blank_i,
    input  logic     v_blank_i,
    input  intr_t    intr_status_i,
    output intr_t    intr_mask_o,
    output intr_t    intr_clear_o
);

    logic     wr_strobe;
    logic     rd_strobe;
    reg_num_t reg_num;
    logic     bytesel;
    byte_t    wr_byte;
    logic     vram_busy;
    logic     vram_hit;
    word_t    vram_word;
    logic     xr_busy;
    logic     xr_hit;
    word_t    xr_word;
    word_t    timer_word;

    bus_sync u_bus_sync (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .wr_strobe_o   (wr_strobe),
        .rd_strobe_o   (rd_strobe),
        .reg_num_o     (reg_num),
        .bytesel_o     (bytesel),
        .wr_byte_o     (wr_byte)
    );

    access_channel #(
        .HAS_INCR    (1'b1),
        .RD_ADDR_NUM (REG_RD_ADDR),
        .WR_ADDR_NUM (REG_WR_ADDR),
        .DATA_NUM    (REG_DATA),
        .RD_INCR_NUM (REG_RD_INCR),
        .WR_INCR_NUM (REG_WR_INCR)
    ) u_vram_chan (
        .clk         (clk),
        .reset_i     (reset_i),
        .wr_strobe_i (wr_strobe),
        .rd_strobe_i (rd_strobe),
        .reg_num_i   (reg_num),
        .bytesel_i   (bytesel),
        .wr_byte_i   (wr_byte),
        .ack_i       (vram_ack_i),
        .rdata_i     (vram_rdata_i),
        .sel_o       (vram_sel_o),
        .wr_o        (vram_wr_o),
        .addr_o      (vram_addr_o),
        .wdata_o     (vram_data_o),
        .busy_o      (vram_busy),
        .rd_hit_o    (vram_hit),
        .rd_word_o   (vram_word)
    );

    // XR addresses step by one, increment numbers unused
    access_channel #(
        .HAS_INCR    (1'b0),
        .RD_ADDR_NUM (REG_RD_XADDR),
        .WR_ADDR_NUM (REG_WR_XADDR),
        .DATA_NUM    (REG_XDATA)
    ) u_xr_chan (
        .clk         (clk),
        .reset_i     (reset_i),
        .wr_strobe_i (wr_strobe),
        .rd_strobe_i (rd_strobe),
        .reg_num_i   (reg_num),
        .bytesel_i   (bytesel),
        .wr_byte_i   (wr_byte),
        .ack_i       (xr_ack_i),
        .rdata_i     (xr_rdata_i),
        .sel_o       (xr_sel_o),
        .wr_o        (xr_wr_o),
        .addr_o      (xr_addr_o),
        .wdata_o     (xr_data_o),
        .busy_o      (xr_busy),
        .rd_hit_o    (xr_hit),
        .rd_word_o   (xr_word)
    );

    tick_timer #(
        .CLK_REDUCED (CLK_REDUCED),
        .HZ_REDUCED  (HZ_REDUCED)
    ) u_timer (
        .clk          (clk),
        .reset_i      (reset_i),
        .rd_strobe_i  (rd_strobe),
        .bytesel_i    (bytesel),
        .timer_word_o (timer_word)
    );

    sys_regs u_sys_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .wr_strobe_i   (wr_strobe),
        .reg_num_i     (reg_num),
        .bytesel_i     (bytesel),
        .wr_byte_i     (wr_byte),
        .timer_word_i  (timer_word),
        .vram_busy_i   (vram_busy),
        .xr_busy_i     (xr_busy),
        .vram_hit_i    (vram_hit),
        .vram_word_i   (vram_word),
        .xr_hit_i      (xr_hit),
        .xr_word_i     (xr_word),
        .h_blank_i     (h_blank_i),
        .v_blank_i     (v_blank_i),
        .intr_status_i (intr_status_i),
        .wrmask_o      (wrmask_o),
        .intr_mask_o   (intr_mask_o),
        .intr_clear_o  (intr_clear_o),
        .bus_data_o    (bus_data_o)
    );

endmodule

/* verification/reg_interface_chk.sv */
// bound assertions on reset state, memory request stability and the interrupt clear pulse
`timescale 1ns/1ps

module reg_interface_chk
    import regif_pkg::*;
(
    input logic    clk,
    input logic    reset_i,
    input logic    vram_sel_i,
    input logic    vram_wr_i,
    input addr_t   vram_addr_i,
    input word_t   vram_data_i,
    input logic    vram_ack_i,
    input logic    xr_sel_i,
    input logic    xr_wr_i,
    input addr_t   xr_addr_i,
    input word_t   xr_data_i,
    input logic    xr_ack_i,
    input wrmask_t wrmask_i,
    input intr_t   intr_clear_i
);

    int unsigned assert_fails = 0;

    // first cycle out of reset
    reset_state: assert property (@(posedge clk)
        $fell(reset_i) |-> !vram_sel_i && !xr_sel_i && wrmask_i == 4'b1111)
        else begin
            $error("select or write mask not at reset value after reset");
            assert_fails++;
        end

    // request held until the memory acknowledges, data only matters on writes
    vram_hold: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_i && !vram_ack_i |=> $stable(vram_addr_i) && $stable(vram_wr_i)
            && (!vram_wr_i || $stable(vram_data_i)))
        else begin
            $error("VRAM request changed before ack");
            assert_fails++;
        end

    xr_hold: assert property (@(posedge clk) disable iff (reset_i)
        xr_sel_i && !xr_ack_i |=> $stable(xr_addr_i) && $stable(xr_wr_i)
            && (!xr_wr_i || $stable(xr_data_i)))
        else begin
            $error("XR request changed before ack");
            assert_fails++;
        end

    clear_pulse: assert property (@(posedge clk) disable iff (reset_i)
        intr_clear_i != '0 |=> intr_clear_i == '0)
        else begin
            $error("interrupt clear held longer than one cycle");
            assert_fails++;
        end

endmodule

/* verification/tb_reg_interface.sv */
// memory model and testbench for the host register interface
`timescale 1ns/1ps

module mem_model
    import regif_pkg::*;
(
    input  logic    clk,
    input  logic    sel_i,
    input  logic    wr_i,
    input  addr_t   addr_i,
    input  word_t   wdata_i,
    input  wrmask_t mask_i,
    input  logic    hold_i,     // withholds the ack
    output logic    ack_o,
    output word_t   rdata_o
);

    addr_t       log_addr[$];   // every write, in order
    word_t       log_data[$];
    wrmask_t     log_mask[$];
    logic [15:0] lfsr;
    logic [1:0]  wait_cnt;

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    // two steps, one bit from each
    function automatic logic [1:0] delay_from(input logic [15:0] state);
        logic [15:0] s1;
        logic [15:0] s2;
        s1 = lfsr_next(state);
        s2 = lfsr_next(s1);
        delay_from = {s1[0], s2[0]};
    endfunction

    initial begin
        ack_o    = 1'b0;
        rdata_o  = '0;
        lfsr     = 16'd35;
        wait_cnt = delay_from(lfsr);
        lfsr     = lfsr_next(lfsr_next(lfsr));
    end

    always @(posedge clk) begin
        ack_o <= 1'b0;
        if (sel_i && !ack_o && !hold_i) begin
            if (wait_cnt == 2'd0) begin
                ack_o   <= 1'b1;
                rdata_o <= ~addr_i;     // inverted address as read data
                if (wr_i) begin
                    log_addr.push_back(addr_i);
                    log_data.push_back(wdata_i);
                    log_mask.push_back(mask_i);
                end
                wait_cnt <= delay_from(lfsr);
                lfsr     <= lfsr_next(lfsr_next(lfsr));
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

module tb_reg_interface
    import regif_pkg::*;
();

    localparam integer TICK_NUM        = 2;     // 10 kHz from 25.125 MHz
    localparam integer TICK_DEN        = 5025;
    localparam integer BYTE_CYCLES     = 8;     // 5 low, 3 high
    localparam integer ACCESS_BUDGET   = 125;
    localparam integer TIMER_GAP       = 9000;
    localparam integer WATCHDOG_CYCLES = 2 * (TIMER_GAP + ACCESS_BUDGET * BYTE_CYCLES);

    logic     clk;
    logic     reset_i;
    logic     bus_cs_n_i;
    logic     bus_rd_nwr_i;
    reg_num_t bus_reg_num_i;
    logic     bus_bytesel_i;
    byte_t    bus_data_i;
    byte_t    bus_data_o;
    logic     vram_ack_i;
    word_t    vram_rdata_i;
    logic     vram_sel_o;
    logic     vram_wr_o;
    addr_t    vram_addr_o;
    word_t    vram_data_o;
    wrmask_t  wrmask_o;
    logic     xr_ack_i;
    word_t    xr_rdata_i;
    logic     xr_sel_o;
    logic     xr_wr_o;
    addr_t    xr_addr_o;
    word_t    xr_data_o;
    logic     h_blank_i;
    logic     v_blank_i;
    intr_t    intr_status_i;
    intr_t    intr_mask_o;
    intr_t    intr_clear_o;
    logic     vram_hold;

    int          test_num     = 0;
    int          test_errs    = 0;
    int          test_checks  = 0;
    int          total_errs   = 0;
    int          total_checks = 0;
    int          tests_failed = 0;
    int          clear_cycles = 0;
    intr_t       clear_seen   = '0;
    int unsigned cycle_cnt    = 0;

    reg_interface u_reg_interface (.*);

    mem_model u_vram_model (
        .clk     (clk),
        .sel_i   (vram_sel_o),
        .wr_i    (vram_wr_o),
        .addr_i  (vram_addr_o),
        .wdata_i (vram_data_o),
        .mask_i  (wrmask_o),
        .hold_i  (vram_hold),
        .ack_o   (vram_ack_i),
        .rdata_o (vram_rdata_i)
    );

    mem_model u_xr_model (
        .clk     (clk),
        .sel_i   (xr_sel_o),
        .wr_i    (xr_wr_o),
        .addr_i  (xr_addr_o),
        .wdata_i (xr_data_o),
        .mask_i  (4'b1111),
        .hold_i  (1'b0),
        .ack_o   (xr_ack_i),
        .rdata_o (xr_rdata_i)
    );

    bind reg_interface reg_interface_chk u_chk (
        .clk          (clk),
        .reset_i      (reset_i),
        .vram_sel_i   (vram_sel_o),
        .vram_wr_i    (vram_wr_o),
        .vram_addr_i  (vram_addr_o),
        .vram_data_i  (vram_data_o),
        .vram_ack_i   (vram_ack_i),
        .xr_sel_i     (xr_sel_o),
        .xr_wr_i      (xr_wr_o),
        .xr_addr_i    (xr_addr_o),
        .xr_data_i    (xr_data_o),
        .xr_ack_i     (xr_ack_i),
        .wrmask_i     (wrmask_o),
        .intr_clear_i (intr_clear_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    always @(negedge clk) begin
        if (intr_clear_o != '0) begin
            clear_cycles = clear_cycles + 1;
            clear_seen   = intr_clear_o;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic expect_equal(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        test_checks++;
        assert (got === exp) else begin
            $display("error t=%0t %s: got %h expected %h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    // one byte cycle, read data sampled once the strobe has settled the mux
    task automatic bus_access(input logic rd, input reg_num_t num, input logic odd,
                              input byte_t wdata, output byte_t rdata);
        @(posedge clk);
        bus_cs_n_i    <= 1'b0;
        bus_rd_nwr_i  <= rd;
        bus_reg_num_i <= num;
        bus_bytesel_i <= odd;
        bus_data_i    <= wdata;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rdata = bus_data_o;
        repeat (2) @(posedge clk);
        bus_cs_n_i <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    task automatic write_byte(input reg_num_t num, input logic odd, input byte_t data);
        byte_t unused;
        bus_access(1'b0, num, odd, data, unused);
    endtask

    task automatic write_word(input reg_num_t num, input word_t data);
        write_byte(num, 1'b0, data[15:8]);
        write_byte(num, 1'b1, data[7:0]);
    endtask

    task automatic read_word(input reg_num_t num, output word_t data);
        byte_t hi;
        byte_t lo;
        bus_access(1'b1, num, 1'b0, 8'h00, hi);
        bus_access(1'b1, num, 1'b1, 8'h00, lo);
        data = {hi, lo};
    endtask

    task automatic wait_mem_idle();
        int n;
        n = 0;
        while ((vram_sel_o || xr_sel_o) && n < 40) begin
            @(negedge clk);
            n++;
        end
        test_checks++;
        assert (!vram_sel_o && !xr_sel_o) else begin
            $display("memory request still pending after %0d cycles at t=%0t", n, $time);
            test_errs++;
        end
        repeat (3) @(posedge clk);  // address advance lands
    endtask

    task automatic finish_test(input string name);
        test_num++;
        total_errs   += test_errs;
        total_checks += test_checks;
        if (test_errs != 0) tests_failed++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, name, test_checks, test_errs);
        test_errs   = 0;
        test_checks = 0;
    endtask

    initial begin
        word_t  w;
        word_t  first_w;
        word_t  delta;
        addr_t  base;
        byte_t  b;
        int     k;
        int     clears_before;
        int     start;
        int     mid;
        real    expect_ticks;
        int     chk_fails;
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        h_blank_i     = 1'b0;
        v_blank_i     = 1'b0;
        intr_status_i = '0;
        vram_hold     = 1'b0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        write_word(REG_RD_INCR, 16'h0003);
        write_word(REG_WR_INCR, 16'h0120);
        write_word(REG_RD_ADDR, 16'h4A10);
        write_word(REG_WR_ADDR, 16'h8001);
        write_word(REG_RD_XADDR, 16'h0C3F);
        write_word(REG_WR_XADDR, 16'h00F0);
        wait_mem_idle();
        write_word(4'hB, 16'hFFFF);
        read_word(REG_RD_INCR, w);
        expect_equal("RD_INCR", w, 16'h0003);
        read_word(REG_WR_INCR, w);
        expect_equal("WR_INCR", w, 16'h0120);
        read_word(REG_RD_ADDR, w);
        expect_equal("RD_ADDR", w, 16'h4A13);  // moved on by the fetch
        read_word(REG_WR_ADDR, w);
        expect_equal("WR_ADDR", w, 16'h8001);
        read_word(REG_RD_XADDR, w);
        expect_equal("RD_XADDR", w, 16'h0C40);
        read_word(REG_WR_XADDR, w);
        expect_equal("WR_XADDR", w, 16'h00F0);
        for (int r = 11; r < 16; r++) begin
            read_word(reg_num_t'(r), w);
            expect_equal("unused register", w, 16'h0000);
        end
        finish_test("register readback");

        write_byte(REG_SYS_CTRL, 1'b1, 8'h0A);
        write_word(REG_WR_INCR, 16'h0010);
        write_word(REG_WR_ADDR, 16'h1234);
        u_vram_model.log_addr.delete();
        u_vram_model.log_data.delete();
        u_vram_model.log_mask.delete();
        for (k = 0; k < 4; k++) begin
            write_word(REG_DATA, 16'hA500 + k * 16'h0111);
        end
        wait_mem_idle();
        expect_equal("VRAM write count", u_vram_model.log_addr.size(), 4);
        for (k = 0; k < 4 && k < u_vram_model.log_addr.size(); k++) begin
            expect_equal("vram_addr_o", u_vram_model.log_addr[k], 16'h1234 + k * 16'h0010);
            expect_equal("vram_data_o", u_vram_model.log_data[k], 16'hA500 + k * 16'h0111);
            expect_equal("wrmask_o", u_vram_model.log_mask[k], 4'b1010);
        end
        read_word(REG_WR_ADDR, w);
        expect_equal("WR_ADDR", w, 16'h1274);
        write_byte(REG_SYS_CTRL, 1'b1, 8'h0F);
        finish_test("VRAM write with increment");

        write_word(REG_RD_INCR, 16'h0005);
        write_word(REG_RD_ADDR, 16'h0100);
        for (k = 0; k < 4; k++) begin
            base = 16'h0100 + k * 16'h0005;
            read_word(REG_DATA, w);
            expect_equal("VRAM read data", w, ~base);
        end
        wait_mem_idle();
        read_word(REG_RD_ADDR, w);
        expect_equal("RD_ADDR", w, 16'h0119);   // five fetches of 5
        finish_test("VRAM read with pre-read");

        write_word(REG_WR_XADDR, 16'h0040);
        u_xr_model.log_addr.delete();
        u_xr_model.log_data.delete();
        for (k = 0; k < 3; k++) begin
            write_word(REG_XDATA, 16'h3C00 + k);
        end
        wait_mem_idle();
        expect_equal("XR write count", u_xr_model.log_addr.size(), 3);
        for (k = 0; k < 3 && k < u_xr_model.log_addr.size(); k++) begin
            expect_equal("xr_addr_o", u_xr_model.log_addr[k], 16'h0040 + k);
            expect_equal("xr_data_o", u_xr_model.log_data[k], 16'h3C00 + k);
        end
        write_word(REG_RD_XADDR, 16'h0200);
        for (k = 0; k < 3; k++) begin
            base = 16'h0200 + k;
            read_word(REG_XDATA, w);
            expect_equal("XR read data", w, ~base);
        end
        wait_mem_idle();
        read_word(REG_RD_XADDR, w);
        expect_equal("RD_XADDR", w, 16'h0204);
        finish_test("XR channel");

        @(posedge clk);
        intr_status_i <= 7'h2A;
        h_blank_i     <= 1'b1;
        v_blank_i     <= 1'b0;
        write_byte(REG_INT_CTRL, 1'b0, 8'h55);
        read_word(REG_INT_CTRL, w);
        expect_equal("INT_CTRL", w, {1'b0, 7'h55, 1'b0, 7'h2A});
        expect_equal("intr_mask_o", intr_mask_o, 7'h55);
        clears_before = clear_cycles;
        write_byte(REG_INT_CTRL, 1'b1, 8'h13);
        repeat (2) @(posedge clk);
        expect_equal("intr_clear_o cycles", clear_cycles - clears_before, 1);
        expect_equal("intr_clear_o", clear_seen, 7'h13);
        write_byte(REG_SYS_CTRL, 1'b1, 8'h05);
        read_word(REG_SYS_CTRL, w);
        expect_equal("SYS_CTRL", w, {4'b0000, 1'b1, 1'b0, 6'b0, 4'b0101});
        @(posedge clk);
        h_blank_i <= 1'b0;
        v_blank_i <= 1'b1;
        read_word(REG_SYS_CTRL, w);
        expect_equal("SYS_CTRL", w, {4'b0000, 1'b0, 1'b1, 6'b0, 4'b0101});
        expect_equal("wrmask_o", wrmask_o, 4'b0101);
        u_vram_model.log_data.delete();
        @(posedge clk);
        vram_hold <= 1'b1;      // VRAM stays busy until released
        write_word(REG_DATA, 16'h7E81);
        bus_access(1'b1, REG_SYS_CTRL, 1'b0, 8'h00, b);
        expect_equal("SYS_CTRL busy bit", b[7], 1'b1);
        @(posedge clk);
        vram_hold <= 1'b0;
        wait_mem_idle();
        bus_access(1'b1, REG_SYS_CTRL, 1'b0, 8'h00, b);
        expect_equal("SYS_CTRL busy bit", b[7], 1'b0);
        expect_equal("VRAM write count", u_vram_model.log_data.size(), 1);
        if (u_vram_model.log_data.size() > 0) begin
            expect_equal("vram_data_o", u_vram_model.log_data[0], 16'h7E81);
        end
        write_byte(REG_SYS_CTRL, 1'b1, 8'h0F);
        finish_test("control registers");

        @(negedge clk);
        start = cycle_cnt;
        read_word(REG_TIMER, first_w);
        repeat (TIMER_GAP) @(posedge clk);
        @(negedge clk);
        mid = cycle_cnt;
        read_word(REG_TIMER, w);
        delta = w - first_w;
        expect_ticks = real'(mid - start) * TICK_NUM / TICK_DEN;
        test_checks++;
        assert (real'(delta) >= expect_ticks - 1.0 && real'(delta) <= expect_ticks + 1.0)
        else begin
            $display("error t=%0t timer_word delta: got %0d expected %.2f within 1",
                     $time, delta, expect_ticks);
            test_errs++;
        end
        finish_test("timer");

        chk_fails = u_reg_interface.u_chk.assert_fails;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d bound failures",
                 test_num, tests_failed, total_checks, total_errs, chk_fails);
        if (tests_failed == 0 && total_errs == 0 && chk_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* list.f */
hw/regif_pkg.sv
hw/bus_sync.sv
hw/access_channel.sv
hw/tick_timer.sv
hw/sys_regs.sv
hw/reg_interface.sv
verification/reg_interface_chk.sv
verification/tb_reg_interface.sv

/* Bender.yml */
package:
  name: reg_interface

sources:
  - hw/regif_pkg.sv
  - hw/bus_sync.sv
  - hw/access_channel.sv
  - hw/tick_timer.sv
  - hw/sys_regs.sv
  - hw/reg_interface.sv
  - target: test
    files:
      - verification/reg_interface_chk.sv
      - verification/tb_reg_interface.sv
